//--- verilog/cacheGeometryPkg.sv
package cacheGeometryPkg;

  // Array shape
  localparam int WordBits     = 32;
  localparam int NumSets      = 16;
  localparam int WordsPerLine = 4;
  // Single LRU bit per set only covers two ways
  localparam int NumWays      = 2;

  // Address split, low bits first
  localparam int ByteOffsetBits = 2;
  localparam int OffsetBits     = $clog2(WordsPerLine);
  localparam int IndexBits      = $clog2(NumSets);
  localparam int TagBits        = WordBits - IndexBits - OffsetBits - ByteOffsetBits;

  localparam int WordLsb  = ByteOffsetBits;
  localparam int IndexLsb = WordLsb + OffsetBits;
  localparam int TagLsb   = IndexLsb + IndexBits;

  // Last word of a line transfer
  localparam int LastWord = WordsPerLine - 1;

  typedef logic [WordBits-1:0]         cacheWordT;
  typedef logic [TagBits-1:0]          tagT;
  typedef logic [IndexBits-1:0]        setIndexT;
  typedef logic [OffsetBits-1:0]       wordIndexT;
  typedef logic [WordBits/8-1:0]       byteMaskT;
  typedef logic [$clog2(NumWays)-1:0]  wayIndexT;

endpackage

//--- verilog/cacheControlPkg.sv
package cacheControlPkg;

  // Controller states
  // Ready serves hits, the others stall the CPU
  typedef enum logic [1:0] {
    Ready,
    WriteBack,
    MemRead,
    Flush
  } cacheStateE;

  // Memory bus operation level
  // Held for a whole line, one word per BusReady
  typedef enum logic [1:0] {
    BusIdle,
    BusRead,
    BusWrite
  } busOpE;

endpackage

//--- verilog/cacheWay.sv
`timescale 1ns/1ns

module cacheWay
  import cacheGeometryPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  setIndexT  setIndex,
  input  wordIndexT wordIndex,
  input  tagT       lookupTag,
  input  cacheWordT wData,
  input  byteMaskT  wMask,
  input  logic      wordWE,
  input  logic      tagWE,
  input  logic      dirtyIn,
  input  logic      cleanWE,
  output logic      hit,
  output logic      valid,
  output logic      dirty,
  output tagT       tag,
  output cacheWordT rdWord
);

  cacheWordT dataMem [NumSets][WordsPerLine];
  tagT       tagMem  [NumSets];

  logic [NumSets-1:0] validBits;
  logic [NumSets-1:0] dirtyBits;

  // Line data, byte lanes written under the mask
  always_ff @(posedge clk) begin
    if (wordWE) begin
      for (int lane = 0; lane < $bits(byteMaskT); lane++) begin
        if (wMask[lane]) begin
          dataMem[setIndex][wordIndex][8*lane +: 8] <= wData[8*lane +: 8];
        end
      end
    end
  end

  // Tag store follows the lookup tag
  always_ff @(posedge clk) begin
    if (tagWE) begin
      tagMem[setIndex] <= lookupTag;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (tagWE) begin
        validBits[setIndex] <= 1'b1;
        dirtyBits[setIndex] <= dirtyIn;
      end else if (cleanWE) begin
        dirtyBits[setIndex] <= 1'b0;
      end
    end
  end

  // Read side of the addressed set
  assign valid  = validBits[setIndex];
  assign dirty  = dirtyBits[setIndex];
  assign tag    = tagMem[setIndex];
  assign rdWord = dataMem[setIndex][wordIndex];

  // Valid gates out a stale tag
  assign hit = valid & (tag == lookupTag);

endmodule

//--- verilog/wayMerge.sv
`timescale 1ns/1ns

module wayMerge
  import cacheGeometryPkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [NumWays-1:0] wayHit,
  input  logic [NumWays-1:0] wayValid,
  input  logic [NumWays-1:0] wayDirty,
  input  tagT                wayTag  [NumWays],
  input  cacheWordT          wayWord [NumWays],
  input  setIndexT           setIndex,
  input  wayIndexT           rdWay,
  input  logic               lruTouch,
  output logic               hit,
  output wayIndexT           hitWay,
  output wayIndexT           victimWay,
  output tagT                selTag,
  output logic               selDirty,
  output cacheWordT          rdWord
);

  // One entry per set naming its least recently used way
  wayIndexT [NumSets-1:0] lruBits;

  assign hit = |wayHit;

  // Lowest hitting way, at most one hits anyway
  always_comb begin
    hitWay = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (wayHit[w]) begin
        hitWay = wayIndexT'(w);
      end
    end
  end

  // Invalid ways are filled before LRU is consulted
  always_comb begin
    victimWay = lruBits[setIndex];
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!wayValid[w]) begin
        victimWay = wayIndexT'(w);
      end
    end
  end

  // Addressed way outputs
  assign rdWord   = wayWord[rdWay];
  assign selTag   = wayTag[rdWay];
  assign selDirty = wayDirty[rdWay];

  // With two ways the other one becomes LRU
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruTouch) begin
      lruBits[setIndex] <= ~rdWay;
    end
  end

endmodule

//--- verilog/cacheController.sv
`timescale 1ns/1ns

module cacheController
  import cacheGeometryPkg::*, cacheControlPkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               memRead,
  input  logic               memWrite,
  input  logic [WordBits-1:0] addr,
  input  cacheWordT          writeData,
  input  byteMaskT           byteMask,
  input  logic               clean,
  input  logic               BusReady,
  input  cacheWordT          busRData,
  input  logic               hit,
  input  wayIndexT           hitWay,
  input  wayIndexT           victimWay,
  input  tagT                selTag,
  input  logic               selDirty,
  input  cacheWordT          rdWord,
  output logic               Stall,
  output busOpE              busOp,
  output logic [WordBits-1:0] busAddr,
  output cacheWordT          busWData,
  output setIndexT           setIndex,
  output wordIndexT          wordIndex,
  output tagT                lookupTag,
  output cacheWordT          wayWData,
  output byteMaskT           wayMask,
  output logic [NumWays-1:0] wordWE,
  output logic [NumWays-1:0] tagWE,
  output logic               dirtyIn,
  output logic [NumWays-1:0] cleanWE,
  output wayIndexT           rdWay,
  output logic               lruTouch
);

  cacheStateE state, nextState;

  setIndexT  reqSet;
  wordIndexT reqWord;
  tagT       reqTag;
  wordIndexT wordCount;
  wayIndexT  victimReg;
  logic      flushing;
  logic      request, missStart, lastBeat, flushDone;

  // Flush walk visits {set, way} in order
  logic [IndexBits:0] flushCount;
  setIndexT           flushSet;
  wayIndexT           flushWay;

  assign reqSet  = addr[IndexLsb +: IndexBits];
  assign reqWord = addr[WordLsb +: OffsetBits];
  assign reqTag  = addr[TagLsb +: TagBits];

  assign {flushSet, flushWay} = flushCount;

  assign request   = memRead | memWrite;
  assign missStart = (state == Ready) & ~clean & request & ~hit;
  assign lastBeat  = BusReady & (wordCount == wordIndexT'(LastWord));
  assign flushDone = (flushCount == '1);

  always_comb begin
    nextState = state;
    case (state)
      Ready: begin
        if (clean) begin
          nextState = Flush;
        end else if (missStart) begin
          nextState = selDirty ? WriteBack : MemRead;
        end
      end
      WriteBack: begin
        if (lastBeat) begin
          nextState = flushing ? Flush : MemRead;
        end
      end
      MemRead: begin
        if (lastBeat) begin
          nextState = Ready;
        end
      end
      Flush: begin
        if (selDirty) begin
          nextState = WriteBack;
        end else if (flushDone) begin
          nextState = Ready;
        end
      end
      default: nextState = Ready;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state      <= Ready;
      flushing   <= 1'b0;
      victimReg  <= '0;
      wordCount  <= '0;
      flushCount <= '0;
    end else begin
      state <= nextState;
      if (state == Ready && clean) begin
        flushing <= 1'b1;
      end else if (state == Flush && nextState == Ready) begin
        flushing <= 1'b0;
      end
      if (missStart) begin
        victimReg <= victimWay;
      end else if (state == Flush && selDirty) begin
        victimReg <= flushWay;
      end
      // Bus word counter, wraps back to 0 after the last word
      if ((state == WriteBack || state == MemRead) && BusReady) begin
        wordCount <= wordCount + wordIndexT'(1);
      end
      // A dirty entry is revisited once it has been written back
      if (state == Flush && !selDirty) begin
        flushCount <= flushCount + {{IndexBits{1'b0}}, 1'b1};
      end
    end
  end

  // Array addressing
  assign setIndex  = (state == Flush || flushing) ? flushSet : reqSet;
  assign wordIndex = (state == Ready) ? reqWord : wordCount;
  assign lookupTag = reqTag;

  always_comb begin
    wordWE   = '0;
    tagWE    = '0;
    cleanWE  = '0;
    dirtyIn  = 1'b0;
    wayWData = writeData;
    wayMask  = byteMask;
    rdWay    = victimReg;
    lruTouch = 1'b0;
    case (state)
      Ready: begin
        rdWay = hit ? hitWay : victimWay;
        if (!clean && request && hit) begin
          lruTouch = 1'b1;
          // Tag rewrite is the same tag and just sets dirty
          if (memWrite) begin
            wordWE[hitWay] = 1'b1;
            tagWE[hitWay]  = 1'b1;
            dirtyIn        = 1'b1;
          end
        end
      end
      WriteBack: cleanWE[victimReg] = lastBeat;
      MemRead: begin
        wayWData           = busRData;
        wayMask            = '1;
        wordWE[victimReg]  = BusReady;
        tagWE[victimReg]   = lastBeat;
      end
      Flush: rdWay = flushWay;
      default: ;
    endcase
  end

  // Bus side
  always_comb begin
    case (state)
      WriteBack: busOp = BusWrite;
      MemRead:   busOp = BusRead;
      default:   busOp = BusIdle;
    endcase
  end

  // Write-back goes out at the victim's old tag
  assign busAddr  = {(state == WriteBack) ? selTag : reqTag, setIndex, wordCount,
                     {ByteOffsetBits{1'b0}}};
  assign busWData = rdWord;

  assign Stall = (state != Ready) | clean | (request & ~hit);

endmodule

//--- verilog/dataCache.sv
`timescale 1ns/1ns

module dataCache
  import cacheGeometryPkg::*, cacheControlPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  // CPU side
  input  logic                memRead,
  input  logic                memWrite,
  input  logic [WordBits-1:0] addr,
  input  cacheWordT           writeData,
  input  byteMaskT            byteMask,
  input  logic                clean,
  output cacheWordT           readData,
  output logic                Stall,
  // Memory bus
  output busOpE               busOp,
  output logic [WordBits-1:0] busAddr,
  output cacheWordT           busWData,
  input  cacheWordT           busRData,
  input  logic                BusReady
);

  setIndexT           setIndex;
  wordIndexT          wordIndex;
  tagT                lookupTag;
  cacheWordT          wayWData;
  byteMaskT           wayMask;
  logic [NumWays-1:0] wordWE, tagWE, cleanWE;
  logic               dirtyIn;
  wayIndexT           rdWay;
  logic               lruTouch;

  logic [NumWays-1:0] wayHit, wayValid, wayDirty;
  tagT                wayTag  [NumWays];
  cacheWordT          wayWord [NumWays];

  logic      hit, selDirty;
  wayIndexT  hitWay, victimWay;
  tagT       selTag;

  cacheController controller (
    .clk, .reset,
    .memRead, .memWrite, .addr, .writeData, .byteMask, .clean,
    .BusReady, .busRData,
    .hit, .hitWay, .victimWay, .selTag, .selDirty,
    .rdWord    (readData),
    .Stall, .busOp, .busAddr, .busWData,
    .setIndex, .wordIndex, .lookupTag, .wayWData, .wayMask,
    .wordWE, .tagWE, .dirtyIn, .cleanWE, .rdWay, .lruTouch
  );

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    cacheWay way (
      .clk, .reset,
      .setIndex, .wordIndex, .lookupTag,
      .wData     (wayWData),
      .wMask     (wayMask),
      .wordWE    (wordWE[w]),
      .tagWE     (tagWE[w]),
      .dirtyIn,
      .cleanWE   (cleanWE[w]),
      .hit       (wayHit[w]),
      .valid     (wayValid[w]),
      .dirty     (wayDirty[w]),
      .tag       (wayTag[w]),
      .rdWord    (wayWord[w])
    );
  end

  wayMerge merge (
    .clk, .reset,
    .wayHit, .wayValid, .wayDirty, .wayTag, .wayWord,
    .setIndex, .rdWay, .lruTouch,
    .hit, .hitWay, .victimWay, .selTag, .selDirty,
    .rdWord    (readData)
  );

endmodule

//--- tb/memoryModel.sv
`timescale 1ns/1ns

module memoryModel
  import cacheGeometryPkg::*, cacheControlPkg::*;
(
  input  logic                clk,
  input  busOpE               busOp,
  input  logic [WordBits-1:0] busAddr,
  input  cacheWordT           busWData,
  output cacheWordT           busRData,
  output logic                BusReady,
  // Backdoor read for end-of-test compares
  input  logic [WordBits-1:0] peekAddr,
  output cacheWordT           peekData
);

  localparam int MemWords    = 1024;
  localparam int MemAddrBits = $clog2(MemWords);

  cacheWordT mem [MemWords];
  integer    seed;
  int        idleCycles;
  logic [MemAddrBits-1:0] wordAddr;

  assign wordAddr = busAddr[MemAddrBits+1:2];
  assign peekData = mem[peekAddr[MemAddrBits+1:2]];

  // One process owns the array and the bus answers
  initial begin
    seed = 32'h2b19_1ad8;
    BusReady = 1'b0;
    busRData = '0;
    // Each word starts as the complement of its byte address
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = ~cacheWordT'(i * 4);
    end
    idleCycles = $unsigned($random(seed)) % 4;
    forever begin
      @(posedge clk);
      #1;
      BusReady = 1'b0;
      if (busOp != BusIdle) begin
        if (idleCycles == 0) begin
          // Word moves in this BusReady cycle
          BusReady = 1'b1;
          if (busOp == BusWrite) begin
            mem[wordAddr] = busWData;
          end else begin
            busRData = mem[wordAddr];
          end
          idleCycles = $unsigned($random(seed)) % 4;
        end else begin
          idleCycles = idleCycles - 1;
        end
      end
    end
  end

endmodule

//--- tb/dataCacheTb.sv
`timescale 1ns/1ns

module dataCacheTb
  import cacheGeometryPkg::*, cacheControlPkg::*;
();

  localparam int ClkPeriod    = 8;
  localparam int StallTimeout = 200;
  localparam int FlushTimeout = 4000;
  localparam int TestWords    = 1024;
  localparam int ImageBits    = $clog2(TestWords);
  localparam int RandomOps    = 400;
  localparam int RandomLines  = 64;

  logic                clk, reset;
  logic                memRead, memWrite, clean;
  logic [WordBits-1:0] addr, busAddr, peekAddr;
  cacheWordT           writeData, readData, busWData, busRData, peekData;
  byteMaskT            byteMask;
  logic                Stall, BusReady;
  busOpE               busOp;

  // Flat memory image with every completed write merged in
  cacheWordT refImage [TestWords];
  busOpE     opLog [$];
  busOpE     lastOp = BusIdle;
  int        readsChecked = 0;
  integer    seed;

  dataCache UUT (
    .clk, .reset, .memRead, .memWrite, .addr, .writeData, .byteMask, .clean,
    .readData, .Stall, .busOp, .busAddr, .busWData, .busRData, .BusReady
  );

  memoryModel memory (
    .clk, .busOp, .busAddr, .busWData, .busRData, .BusReady, .peekAddr, .peekData
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic cacheWordT expectedWord(input logic [WordBits-1:0] a);
    return refImage[a[ImageBits+1:2]];
  endfunction

  function automatic cacheWordT mergeBytes(input cacheWordT oldWord, input cacheWordT newWord,
                                           input byteMaskT mask);
    cacheWordT result;
    result = oldWord;
    for (int lane = 0; lane < $bits(byteMaskT); lane++) begin
      if (mask[lane]) begin
        result[8*lane +: 8] = newWord[8*lane +: 8];
      end
    end
    return result;
  endfunction

  task automatic failRun();
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkReadData(input cacheWordT actual, input cacheWordT expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: readData = %h, expected %h (addr %h)",
               $time, actual, expected, addr);
      failRun();
    end
  endtask

  task automatic checkMemWord(input logic [WordBits-1:0] a, input cacheWordT actual,
                              input cacheWordT expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: memory word %h = %h, expected %h", $time, a, actual, expected);
      failRun();
    end
  endtask

  task automatic checkBusOp(input busOpE actual, input busOpE expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: busOp = %s, expected %s", $time, actual.name(), expected.name());
      failRun();
    end
  endtask

  task automatic checkStall(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: Stall = %b, expected %b", $time, actual, expected);
      failRun();
    end
  endtask

  // Reads are compared whenever one completes
  always @(negedge clk) begin
    if (!reset && memRead && !Stall) begin
      checkReadData(readData, expectedWord(addr));
      readsChecked++;
    end
  end

  // Order of bus operations, idle gaps dropped
  always @(negedge clk) begin
    if (busOp != lastOp && busOp != BusIdle) begin
      opLog.push_back(busOp);
    end
    lastOp = busOp;
  end

  // One CPU request, held until Stall is low at a rising edge
  task automatic access(input logic isWrite, input logic [WordBits-1:0] a, input cacheWordT data,
                        input byteMaskT mask, output int stalls);
    int cycles;
    memRead   = ~isWrite;
    memWrite  = isWrite;
    addr      = a;
    writeData = data;
    byteMask  = mask;
    cycles    = 0;
    @(negedge clk);
    while (Stall) begin
      if (cycles >= StallTimeout) begin
        $display("Timeout: Stall still high %0d cycles after the request to %h", cycles, a);
        failRun();
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    if (isWrite) begin
      refImage[a[ImageBits+1:2]] = mergeBytes(expectedWord(a), data, mask);
    end
    #1;
    memRead  = 1'b0;
    memWrite = 1'b0;
    stalls   = cycles;
  endtask

  task automatic runFlush();
    int cycles;
    clean = 1'b1;
    @(negedge clk);
    checkStall(Stall, 1'b1);
    @(posedge clk);
    #1;
    clean  = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (Stall) begin
      if (cycles >= FlushTimeout) begin
        $display("Timeout: flush still running after %0d cycles", cycles);
        failRun();
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic compareMemory();
    for (int i = 0; i < TestWords; i++) begin
      peekAddr = i * 4;
      #1;
      checkMemWord(peekAddr, peekData, refImage[i]);
    end
  endtask

  initial begin
    int stalls;
    int line;
    int word;
    int logStart;
    logic [WordBits-1:0] a;
    cacheWordT data;
    byteMaskT mask;

    seed      = 32'h2b19_1ad8;
    reset     = 1'b1;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    clean     = 1'b0;
    addr      = '0;
    writeData = '0;
    byteMask  = '0;
    peekAddr  = '0;
    for (int i = 0; i < TestWords; i++) begin
      refImage[i] = ~cacheWordT'(i * 4);
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle after reset
    checkStall(Stall, 1'b0);
    checkBusOp(busOp, BusIdle);

    // Misses fill two lines, second pass must hit
    for (int pass = 0; pass < 2; pass++) begin
      for (int w = 0; w < WordsPerLine; w++) begin
        access(1'b0, 32'(w * 4), '0, '0, stalls);
        if (pass == 1) checkStall(stalls != 0, 1'b0);
        access(1'b0, 32'(32'h140 + w * 4), '0, '0, stalls);
        if (pass == 1) checkStall(stalls != 0, 1'b0);
      end
    end

    // Byte lanes on a resident line
    access(1'b0, 32'h10, '0, '0, stalls);
    access(1'b1, 32'h14, 32'haabb_ccdd, 4'b0101, stalls);
    checkStall(stalls != 0, 1'b0);
    access(1'b1, 32'h14, 32'h1122_3344, 4'b1000, stalls);
    checkStall(stalls != 0, 1'b0);
    access(1'b1, 32'h18, 32'hdead_beef, 4'b0011, stalls);
    checkStall(stalls != 0, 1'b0);
    access(1'b1, 32'h1c, 32'hcafe_f00d, 4'b1111, stalls);
    checkStall(stalls != 0, 1'b0);
    for (int w = 0; w < WordsPerLine; w++) begin
      access(1'b0, 32'(32'h10 + w * 4), '0, '0, stalls);
    end

    // Set 5, three tags, the dirty line is evicted
    access(1'b1, 32'h154, 32'h0123_4567, 4'b1111, stalls);
    access(1'b0, 32'h250, '0, '0, stalls);
    logStart = opLog.size();
    access(1'b0, 32'h358, '0, '0, stalls);
    if (opLog.size() < logStart + 2) begin
      $display("Eviction of a dirty line did not produce a write-back and a fill");
      failRun();
    end
    checkBusOp(opLog[logStart], BusWrite);
    checkBusOp(opLog[logStart + 1], BusRead);
    access(1'b0, 32'h154, '0, '0, stalls);

    runFlush();
    compareMemory();

    // Random traffic over 64 lines
    for (int n = 0; n < RandomOps; n++) begin
      line = $unsigned($random(seed)) % RandomLines;
      word = $unsigned($random(seed)) % WordsPerLine;
      a    = 32'(line * 16 + word * 4);
      data = $random(seed);
      mask = byteMaskT'($random(seed));
      access(($random(seed) & 1) == 1, a, data, mask, stalls);
    end
    runFlush();
    compareMemory();

    if (readsChecked > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("No read completed during the run");
      failRun();
    end
  end

endmodule

//--- dataCache.f
verilog/cacheGeometryPkg.sv
verilog/cacheControlPkg.sv
verilog/cacheWay.sv
verilog/wayMerge.sv
verilog/cacheController.sv
verilog/dataCache.sv
tb/memoryModel.sv
tb/dataCacheTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = dataCacheTb
FILELIST = dataCache.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSTEXT = TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	-./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASSTEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
